// File: all.f
+incdir+include
verilog/xc_pkg.sv
verilog/xc_lane_if.sv
verilog/line_sampler.sv
verilog/lane_correlator.sv
verilog/frame_packer.sv
verilog/xc_core.sv
dv/xc_core_tb.sv

// File: dv/xc_core_tb.sv
// Correlator core testbench: random line pulses, reference counts and word burst checking.
`timescale 1ns/100ps
`default_nettype none

`include "xc_defs.svh"

module xc_core_tb
    import xc_pkg::*;
();

    localparam int n_lines    = `XC_NUM_LINES;
    localparam int res_w      = `XC_RESOLUTION;
    localparam int frame_len  = `XC_FRAME_CYCLES;
    localparam int num_frames = 7;      // Stimulus frames, one burst each.
    localparam int max_events = 64;     // Room for one frame's pulse events.
    localparam int seed       = 34661;

    logic                      clk;
    logic                      rst_n;
    logic [n_lines-1:0]        line_in;
    logic [res_w-1:0]          word_data;
    logic [`XC_LANE_IDX_W-1:0] word_lane;
    word_kind_e                word_kind;
    logic                      word_valid;

    int                 cyc = 0;                // Posedges since reset release.
    logic [n_lines-1:0] ev_mask  [max_events];  // Lines that rise in each event.
    int                 ev_start [max_events];  // Frame cycle of the rising edge.
    int                 ev_high  [max_events];  // High time in clocks.
    int                 ev_cnt;
    logic [res_w-1:0]   exp_auto  [n_lines];    // Model counts of the current frame.
    logic [res_w-1:0]   exp_cross [n_lines];
    logic [res_w-1:0]   exp_words [$];          // Expected burst data, in word order.
    int                 exp_test  [$];          // Test that owns each queued frame.
    bit                 exp_last  [$];          // Frame closes its test.
    int                 test_err  [1:5];
    string              test_name [1:5];
    int                 bursts_checked = 0;
    bit                 timed_out = 1'b0;

    xc_core uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .line_in    (line_in),
        .word_data  (word_data),
        .word_lane  (word_lane),
        .word_kind  (word_kind),
        .word_valid (word_valid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period.
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            cyc <= 0;
        end else begin
            cyc <= cyc + 1;  // Frame j covers cycles j*F to j*F+F-1.
        end
    end

    task automatic check_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v, input int tid);
        assert (act_v === exp_v) else begin
            $display("[ERROR] t=%0t %s expected 0x%0h actual 0x%0h", $time, name, exp_v, act_v);
            test_err[tid]++;
        end
    endtask

    // Returns on the falling edge where the cycle count reaches the target.
    task automatic wait_until_cycle(input int target);
        int guard;
        guard = 0;
        while (cyc < target && !timed_out) begin
            @(negedge clk);
            guard++;
            if (guard > 2 * frame_len) begin
                $display("Timeout: stimulus never reached cycle %0d.", target);
                timed_out = 1'b1;
            end
        end
    endtask

    // Mode 0 idle, 1 single lines, 2 chosen pairs, 3 random masks.
    task automatic gen_events(input int mode);
        int                 t;
        int                 high;
        int                 i;
        int                 pick;
        logic [n_lines-1:0] mask;
        ev_cnt = 0;
        t      = 8;  // Keep clear of the frame edges.
        while (mode != 0 && ev_cnt < max_events) begin
            high = int'($urandom_range(4, 2));
            if (t + high > frame_len - 8) break;
            i    = int'($urandom_range(n_lines - 1, 0));
            pick = int'($urandom_range(2, 0));
            mask = '0;
            case (mode)
                1: mask[i] = 1'b1;
                2: begin
                    mask[i] = 1'b1;
                    if (ev_cnt == 0) begin
                        mask            = '0;
                        mask[n_lines-1] = 1'b1;  // Wrap pair first.
                        mask[0]         = 1'b1;
                    end else if (pick == 0) begin
                        mask[(i + 1) % n_lines] = 1'b1;  // Neighbors.
                    end else if (pick == 1) begin
                        mask[(i + 2) % n_lines] = 1'b1;  // Not neighbors, no cross.
                    end
                end
                default: mask = n_lines'($urandom_range((1 << n_lines) - 1, 1));
            endcase
            ev_mask[ev_cnt]  = mask;
            ev_start[ev_cnt] = t;
            ev_high[ev_cnt]  = high;
            ev_cnt++;
            t = t + high + int'($urandom_range(5, 2));  // At least 2 low clocks.
        end
    endtask

    // Events never overlap, so each one is a clean edge on every line in its mask.
    function automatic void ref_counts();
        int                 a [n_lines];
        int                 x [n_lines];
        logic [res_w-1:0]   cnt_max;
        cnt_max = '1;
        for (int i = 0; i < n_lines; i++) begin
            a[i] = 0;
            x[i] = 0;
        end
        for (int e = 0; e < ev_cnt; e++) begin
            for (int i = 0; i < n_lines; i++) begin
                if (ev_mask[e][i]) a[i]++;
                if (ev_mask[e][i] && ev_mask[e][(i + 1) % n_lines]) x[i]++;
            end
        end
        for (int i = 0; i < n_lines; i++) begin
            exp_auto[i]  = (a[i] >= int'(cnt_max)) ? cnt_max : res_w'(a[i]);  // Saturate.
            exp_cross[i] = (x[i] >= int'(cnt_max)) ? cnt_max : res_w'(x[i]);
        end
    endfunction

    function automatic int frame_mode(input int f);
        if (f == 0) return 0;
        if (f <= 2) return 1;
        if (f == 3) return 2;
        return 3;
    endfunction

    task automatic drive_frame(input int frame);
        int base;
        base = frame * frame_len;
        for (int e = 0; e < ev_cnt; e++) begin
            wait_until_cycle(base + ev_start[e]);
            line_in = ev_mask[e];
            wait_until_cycle(base + ev_start[e] + ev_high[e]);
            line_in = '0;
        end
    endtask

    initial begin : stimulus
        int guard;
        int pass_cnt;
        int fail_cnt;
        void'($urandom(seed));
        test_name[1] = "reset_idle";
        test_name[2] = "auto_counts";
        test_name[3] = "coincidence";
        test_name[4] = "frame_separation";
        test_name[5] = "burst_format";
        for (int i = 1; i <= 5; i++) test_err[i] = 0;
        line_in = '0;
        rst_n   = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int f = 0; f < num_frames; f++) begin
            gen_events(frame_mode(f));
            ref_counts();
            for (int i = 0; i < n_lines; i++) begin
                exp_words.push_back(exp_auto[i]);
                exp_words.push_back(exp_cross[i]);
            end
            exp_test.push_back(frame_mode(f) + 1);
            exp_last.push_back(f == 0 || f == 2 || f == 3 || f == num_frames - 1);
            drive_frame(f);
        end
        guard = 0;
        while (bursts_checked < num_frames && !timed_out) begin
            @(negedge clk);
            guard++;
            if (guard > 4 * frame_len) begin
                $display("Timeout: only %0d of %0d bursts were checked.",
                         bursts_checked, num_frames);
                timed_out = 1'b1;
            end
        end
        $display("Test 5 %s: %s, %0d errors.", test_name[5],
                 (test_err[5] == 0) ? "pass" : "fail", test_err[5]);
        pass_cnt = 0;
        fail_cnt = 0;
        for (int i = 1; i <= 5; i++) begin
            if (test_err[i] == 0 && !timed_out) pass_cnt++;
            else fail_cnt++;
        end
        $display("Summary: %0d tests passed, %0d tests failed.", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin : burst_checker
        int         guard;
        int         tid;
        bit         last;
        word_kind_e kind_exp;
        guard = 0;
        while (rst_n !== 1'b1 && !timed_out) begin
            @(negedge clk);
            guard++;
            if (guard > 10) begin
                $display("Timeout: reset was never released.");
                timed_out = 1'b1;
            end
        end
        for (int b = 0; b < num_frames && !timed_out; b++) begin
            guard = 0;
            while (word_valid !== 1'b1 && !timed_out) begin
                @(negedge clk);
                guard++;
                if (guard > frame_len + 16) begin
                    $display("Timeout: burst %0d never raised word_valid.", b);
                    timed_out = 1'b1;
                end
            end
            if (!timed_out) begin
                tid  = exp_test.pop_front();
                last = exp_last.pop_front();
                // Frame end plus two clocks.
                check_value("burst start cycle", 32'((b + 1) * frame_len + 1), 32'(cyc),
                            (b == 0) ? 1 : 5);
                for (int k = 0; k < 2 * n_lines; k++) begin
                    if (k > 0) @(negedge clk);
                    kind_exp = (k % 2 == 0) ? kind_auto : kind_cross;  // Auto then cross.
                    check_value("word_valid", 32'd1, 32'(word_valid), 5);
                    check_value("word_lane", 32'(k / 2), 32'(word_lane), 5);
                    check_value("word_kind", 32'(kind_exp), 32'(word_kind), 5);
                    check_value($sformatf("word_data lane %0d %s", k / 2,
                                          (k % 2 == 0) ? "auto" : "cross"),
                                32'(exp_words.pop_front()), 32'(word_data), tid);
                end
                @(negedge clk);
                check_value("word_valid after burst", 32'd0, 32'(word_valid), 5);
                if (last) begin
                    $display("Test %0d %s: %s, %0d errors.", tid, test_name[tid],
                             (test_err[tid] == 0) ? "pass" : "fail", test_err[tid]);
                end
                bursts_checked++;
            end
        end
    end

endmodule

`default_nettype wire

// File: include/xc_defs.svh
// Correlator build constants: line count, counter resolution and frame length.
`ifndef XC_DEFS_SVH
`define XC_DEFS_SVH

// Number of single-bit detector lines, one lane each.
`define XC_NUM_LINES 8

// Width of every live counter, snapshot and output word.
`define XC_RESOLUTION 24

// Integration frame length in clocks.
// Keep it at 2*XC_NUM_LINES + 4 or more so a burst drains before the next frame ends.
`define XC_FRAME_CYCLES 256

// Lane index width carried with each output word.
// The one-line case still gets a single index bit.
`define XC_LANE_IDX_W ((`XC_NUM_LINES > 1) ? $clog2(`XC_NUM_LINES) : 1)

`endif

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the correlator testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=xc_core_sim

verilator --binary --timing --assert -Wno-fatal \
    -f all.f \
    --top-module xc_core_tb \
    -Mdir obj_dir \
    -o "$BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed."
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status."
    exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
    echo "Simulation reported failures, see $LOG."
    exit 1
fi

if ! grep -q "ALL CHECKS PASSED" "$LOG"; then
    echo "Simulation ended without a result line, see $LOG."
    exit 1
fi

echo "Simulation passed."
exit 0

// File: verilog/frame_packer.sv
// Frame packer: streams every lane's auto and cross snapshot as an indexed word burst.
`timescale 1ns/100ps
`default_nettype none

`include "xc_defs.svh"

module frame_packer
    import xc_pkg::*;
(
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    xc_lane_if.packer                      lanes [`XC_NUM_LINES],
    output logic [`XC_RESOLUTION-1:0]      word_data,   // Selected snapshot count.
    output logic [`XC_LANE_IDX_W-1:0]      word_lane,   // Lane the word belongs to.
    output word_kind_e                     word_kind,   // Auto or cross.
    output logic                           word_valid   // Take the word this cycle.
);

    logic [`XC_RESOLUTION-1:0] auto_snap  [`XC_NUM_LINES];  // Gathered auto snapshots.
    logic [`XC_RESOLUTION-1:0] cross_snap [`XC_NUM_LINES];  // Gathered cross snapshots.
    logic                      frame_snap;                  // New snapshot set ready.
    logic                      last_lane;                   // Index at the top lane.
    packer_state_e             state_q;
    logic [`XC_LANE_IDX_W-1:0] idx_q;                       // Lane being emitted.
    word_kind_e                kind_q;                      // Half of the lane pair.

    // Interface arrays only take constant indices, so pull the counts out.
    for (genvar i = 0; i < `XC_NUM_LINES; i++) begin : g_gather
        assign auto_snap[i]  = lanes[i].auto_count;
        assign cross_snap[i] = lanes[i].cross_count;
    end

    // One shared frame strobe, so lane 0 speaks for all lanes.
    assign frame_snap = lanes[0].snap_valid;
    assign last_lane  = (int'(idx_q) == `XC_NUM_LINES - 1);

    // Two words per lane, auto first.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= st_idle;
            idx_q   <= '0;
            kind_q  <= kind_auto;
        end else begin
            case (state_q)
                st_idle: begin
                    if (frame_snap) begin
                        state_q <= st_emit;  // First word on the next clock.
                        idx_q   <= '0;
                        kind_q  <= kind_auto;
                    end
                end
                st_emit: begin
                    if (kind_q == kind_auto) begin
                        kind_q <= kind_cross;  // Same lane, cross half.
                    end else begin
                        kind_q <= kind_auto;
                        if (last_lane) begin
                            idx_q   <= '0;
                            state_q <= st_idle;  // Burst complete.
                        end else begin
                            idx_q <= idx_q + 1'b1;
                        end
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    // Output mux follows the registered index and kind.
    assign word_data  = (kind_q == kind_cross) ? cross_snap[idx_q] : auto_snap[idx_q];
    assign word_lane  = idx_q;
    assign word_kind  = kind_q;
    assign word_valid = (state_q == st_emit);

endmodule

`default_nettype wire

// File: verilog/lane_correlator.sv
// Lane correlator: saturating auto and cross coincidence counts with a frame snapshot.
`timescale 1ns/100ps
`default_nettype none

`include "xc_defs.svh"

module lane_correlator (
    input  wire logic clk,
    input  wire logic rst_n,
    xc_lane_if.lane   lane
);

    logic [`XC_RESOLUTION-1:0] auto_live_q;   // Pulses so far this frame.
    logic [`XC_RESOLUTION-1:0] cross_live_q;  // Coincidences so far this frame.
    logic [`XC_RESOLUTION-1:0] auto_next;     // Live value including this cycle.
    logic [`XC_RESOLUTION-1:0] cross_next;
    logic                      coinc;         // Both lines fired together.
    logic                      snap_valid_q;

    assign coinc = lane.pulse & lane.next_pulse;  // Same-cycle only.

    // Counters stick at all ones.
    always_comb begin
        auto_next  = auto_live_q;
        cross_next = cross_live_q;
        if (lane.pulse && !(&auto_live_q)) begin
            auto_next = auto_live_q + 1'b1;
        end
        if (coinc && !(&cross_live_q)) begin
            cross_next = cross_live_q + 1'b1;
        end
    end

    // Live counters restart after every frame.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            auto_live_q  <= '0;
            cross_live_q <= '0;
            snap_valid_q <= 1'b0;
        end else begin
            snap_valid_q <= lane.frame_end;  // Flags the new snapshot for one clock.
            if (lane.frame_end) begin
                auto_live_q  <= '0;
                cross_live_q <= '0;
            end else begin
                auto_live_q  <= auto_next;
                cross_live_q <= cross_next;
            end
        end
    end

    // The strobe cycle's own pulses still go into the closing frame.
    always_ff @(posedge clk) begin
        if (lane.frame_end) begin
            lane.auto_count  <= auto_next;
            lane.cross_count <= cross_next;
        end
    end

    assign lane.snap_valid = snap_valid_q;

endmodule

`default_nettype wire

// File: verilog/line_sampler.sv
// Line sampler: synchronizes the detector lines, makes edge pulses and the frame strobe.
`timescale 1ns/100ps
`default_nettype none

`include "xc_defs.svh"

module line_sampler (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic [`XC_NUM_LINES-1:0] line_in,  // Raw asynchronous detector lines.
    xc_lane_if.sampler                    lanes [`XC_NUM_LINES]
);

    localparam int frame_cnt_w = $clog2(`XC_FRAME_CYCLES);  // Frame counter width.

    logic [`XC_NUM_LINES-1:0] sync1_q;     // First synchronizer stage.
    logic [`XC_NUM_LINES-1:0] sync2_q;     // Second stage, safe to use.
    logic [`XC_NUM_LINES-1:0] prev_q;      // Synchronized level one clock back.
    logic [`XC_NUM_LINES-1:0] pulse_q;     // Registered rising-edge pulses.
    logic [`XC_NUM_LINES-1:0] rise;        // Edge found this cycle.
    logic [frame_cnt_w-1:0]   frame_cnt_q; // Position inside the frame.
    logic                     frame_end_q; // Strobe in the frame's last cycle.
    logic                     cnt_wrap;    // Counter at its last value.
    logic                     end_next;    // Strobe goes high next cycle.

    assign rise = sync2_q & ~prev_q;  // Low-to-high of the clean level.

    // Line to pulse is three flops deep.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sync1_q <= '0;
            sync2_q <= '0;
            prev_q  <= '0;
            pulse_q <= '0;
        end else begin
            sync1_q <= line_in;
            sync2_q <= sync1_q;
            prev_q  <= sync2_q;
            pulse_q <= rise;  // One cycle wide per edge.
        end
    end

    assign cnt_wrap = (int'(frame_cnt_q) == `XC_FRAME_CYCLES - 1);
    assign end_next = (int'(frame_cnt_q) == `XC_FRAME_CYCLES - 2);

    // Free-running frame timer, the strobe comes once per period.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            frame_cnt_q <= '0;
            frame_end_q <= 1'b0;
        end else begin
            frame_cnt_q <= cnt_wrap ? '0 : frame_cnt_q + 1'b1;
            frame_end_q <= end_next;  // Registered so it lines up with the count wrap.
        end
    end

    // Fan out per lane, each lane sees only itself and its neighbor.
    for (genvar i = 0; i < `XC_NUM_LINES; i++) begin : g_fanout
        assign lanes[i].pulse      = pulse_q[i];
        assign lanes[i].next_pulse = pulse_q[(i + 1) % `XC_NUM_LINES];  // Wraps at the top.
        assign lanes[i].frame_end  = frame_end_q;
    end

endmodule

`default_nettype wire

// File: verilog/xc_core.sv
// Correlator core: line sampler, one correlator lane per line and the output packer.
`timescale 1ns/100ps
`default_nettype none

`include "xc_defs.svh"

module xc_core
    import xc_pkg::*;
(
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic [`XC_NUM_LINES-1:0] line_in,     // Detector lines, asynchronous.
    output logic [`XC_RESOLUTION-1:0]     word_data,   // Count payload.
    output logic [`XC_LANE_IDX_W-1:0]     word_lane,   // Source lane of the word.
    output word_kind_e                    word_kind,   // Auto or cross count.
    output logic                          word_valid   // No back-pressure.
);

    // One bundle per lane, shared by sampler, lane and packer.
    xc_lane_if lane_bus [`XC_NUM_LINES] ();

    // Edges and frame timing.
    line_sampler u_sampler (
        .clk     (clk),
        .rst_n   (rst_n),
        .line_in (line_in),
        .lanes   (lane_bus)
    );

    // Identical counting lanes.
    for (genvar i = 0; i < `XC_NUM_LINES; i++) begin : g_lane
        lane_correlator u_lane (
            .clk   (clk),
            .rst_n (rst_n),
            .lane  (lane_bus[i])
        );
    end

    // Burst out at every frame end.
    frame_packer u_packer (
        .clk        (clk),
        .rst_n      (rst_n),
        .lanes      (lane_bus),
        .word_data  (word_data),
        .word_lane  (word_lane),
        .word_kind  (word_kind),
        .word_valid (word_valid)
    );

endmodule

`default_nettype wire

// File: verilog/xc_lane_if.sv
// Per-lane bundle: edge pulses and frame strobe in, frame snapshot counts out.
`timescale 1ns/100ps
`default_nettype none

`include "xc_defs.svh"

interface xc_lane_if;

    logic                        pulse;        // One-cycle edge pulse of this line.
    logic                        next_pulse;   // Edge pulse of the wrapped neighbor.
    logic                        frame_end;    // Last cycle of the frame.
    logic [`XC_RESOLUTION-1:0]   auto_count;   // Snapshot of the own pulse count.
    logic [`XC_RESOLUTION-1:0]   cross_count;  // Snapshot of the coincidence count.
    logic                        snap_valid;   // Snapshot was just updated.

    modport sampler (
        output pulse,
        output next_pulse,
        output frame_end
    );

    modport lane (
        input  pulse,
        input  next_pulse,
        input  frame_end,
        output auto_count,
        output cross_count,
        output snap_valid
    );

    // The packer only drains the snapshots.
    modport packer (
        input  auto_count,
        input  cross_count,
        input  snap_valid
    );

endinterface

`default_nettype wire

// File: verilog/xc_pkg.sv
// Correlator types: packer FSM states and output word kinds.
`default_nettype none

package xc_pkg;

    // Packer FSM.
    typedef enum logic {
        st_idle = 1'b0,  // Waiting for a frame snapshot.
        st_emit = 1'b1   // Streaming one word per clock.
    } packer_state_e;

    // Tag on every output word.
    typedef enum logic {
        kind_auto  = 1'b0,  // Pulse count of the lane's own line.
        kind_cross = 1'b1   // Same-cycle coincidences with line (i+1) mod N.
    } word_kind_e;

endpackage

`default_nettype wire
